// ==== verilog/heapPkg.sv ====
/*
  Heap array unit shared definitions
  Field widths, value types, opcodes, error kinds and the
  command and response formats used on both queues
*/
`default_nettype none

package heapPkg;

  // ------------------------------------------------------------------
  // Field widths
  // ------------------------------------------------------------------
  localparam int ArrayBits = 2;                       // Four arrays
  localparam int IndexBits = 3;                       // Eight elements per array
  localparam int DataBits  = 12;                      // Element width

  typedef logic [ArrayBits-1:0] arrayId_t;            // Array number
  typedef logic [IndexBits-1:0] index_t;              // Element index
  typedef logic [IndexBits:0]   size_t;               // Size 0 .. 8, one extra bit
  typedef logic [DataBits-1:0]  data_t;               // Element value

  // ------------------------------------------------------------------
  // Commands and error kinds
  // ------------------------------------------------------------------
  typedef enum logic [2:0] {
    OpAlloc = 3'd0,                                   // Hand out an array number
    OpFree  = 3'd1,                                   // Return an array
    OpWrite = 3'd2,                                   // Store, may extend size
    OpRead  = 3'd3,                                   // Fetch below size
    OpSize  = 3'd4,                                   // Report current size
    OpPush  = 3'd5,                                   // Append
    OpPop   = 3'd6,                                   // Remove last
    OpAdd   = 3'd7                                    // Add, return new value
  } heapOp_t;

  typedef enum logic [2:0] {
    ErrNone         = 3'd0,
    ErrNotAllocated = 3'd1,                           // Array never handed out
    ErrFreed        = 3'd2,                           // Array handed out, then freed
    ErrOutOfBounds  = 3'd3,
    ErrFull         = 3'd4,                           // Push on eight elements
    ErrEmpty        = 3'd5,                           // Pop on zero elements
    ErrOutOfMemory  = 3'd6                            // Every array in use
  } heapError_t;

  // ------------------------------------------------------------------
  // Queue payloads
  // ------------------------------------------------------------------
  typedef struct packed {
    heapOp_t  op;
    arrayId_t array;
    index_t   index;
    data_t    data;
  } heapCommand_t;                                    // 20 bits

  typedef struct packed {
    data_t      data;
    heapError_t error;
  } heapResponse_t;                                   // 15 bits

endpackage

`default_nettype wire

// ==== verilog/heapCommandQueue.sv ====
/*
  Heap unit command queue
  Circular FIFO for incoming commands, one credit back per command taken
*/
`timescale 1ns/1ps
`default_nettype none

module heapCommandQueue #(
  parameter int QueueDepth = 4
) (
  input  wire                        clock,
  input  wire                        resetN,
  input  wire heapPkg::heapCommand_t command,
  input  wire                        commandValid,
  input  wire                        take,
  output heapPkg::heapCommand_t      head,
  output logic                       headValid,
  output logic                       commandCredit
);

  localparam int PtrBits   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int CountBits = $clog2(QueueDepth + 1);
  localparam logic [PtrBits-1:0] LastSlot = PtrBits'(QueueDepth - 1);

  heapPkg::heapCommand_t entries [QueueDepth];        // Command storage
  logic [PtrBits-1:0]    readPtr;
  logic [PtrBits-1:0]    writePtr;
  logic [CountBits-1:0]  fill;                        // Commands held

  assign head      = entries[readPtr];
  assign headValid = (fill != '0);

  // ------------------------------------------------------------------
  // Pointers, fill count and credit return
  // ------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      readPtr       <= '0;
      writePtr      <= '0;
      fill          <= '0;
      commandCredit <= 1'b0;
    end else begin
      if (commandValid) begin
        writePtr <= (writePtr == LastSlot) ? '0 : writePtr + 1'b1;
      end
      if (take) begin
        readPtr <= (readPtr == LastSlot) ? '0 : readPtr + 1'b1;
      end
      fill          <= fill + CountBits'(commandValid) - CountBits'(take);
      commandCredit <= take;                          // Slot freed, credit back
    end
  end

  always_ff @(posedge clock) begin
    if (commandValid) begin
      entries[writePtr] <= command;
    end
  end

  // Producer only sends on a held credit, so a full queue sees nothing
  noOverflow: assert property (@(posedge clock) disable iff (!resetN)
    commandValid |-> (fill != CountBits'(QueueDepth)));

endmodule

`default_nettype wire

// ==== verilog/heapArrayStore.sv ====
/*
  Heap array store
  Element memory, sizes and allocation state; executes one command
  per cycle and registers its response
*/
`timescale 1ns/1ps
`default_nettype none

module heapArrayStore (
  input  wire                        clock,
  input  wire                        resetN,
  input  wire heapPkg::heapCommand_t head,
  input  wire                        headValid,
  input  wire                        hasSpace,
  output logic                       take,
  output heapPkg::heapResponse_t     result,
  output logic                       resultValid
);

  localparam int ArrayCount  = 1 << heapPkg::ArrayBits;
  localparam int ArrayLength = 1 << heapPkg::IndexBits;

  typedef logic [heapPkg::ArrayBits:0] arrayCount_t;  // 0 .. ArrayCount

  // ------------------------------------------------------------------
  // State
  // ------------------------------------------------------------------
  heapPkg::data_t        memory [ArrayCount][ArrayLength];
  heapPkg::size_t        sizes [ArrayCount];
  logic [ArrayCount-1:0] allocated;                   // Handed out and not freed
  heapPkg::arrayId_t     freeStack [ArrayCount];      // Most recent free on top
  arrayCount_t           freeTop;
  arrayCount_t           usedCount;                   // Arrays ever handed out

  heapPkg::size_t        sizeNow;
  heapPkg::index_t       elemIndex;                   // Element the command touches
  heapPkg::data_t        elemNow;
  heapPkg::data_t        elemSum;
  heapPkg::arrayId_t     allocId;
  heapPkg::heapError_t   cmdError;
  heapPkg::data_t        resultData;
  logic                  execute;                     // Taken and no error
  logic                  memWrite;

  assign take    = headValid && hasSpace;
  assign execute = take && (cmdError == heapPkg::ErrNone);

  // Push lands on the slot past the end, Pop reads the last one
  always_comb begin
    sizeNow   = sizes[head.array];
    elemIndex = head.index;
    if (head.op == heapPkg::OpPush) begin
      elemIndex = sizeNow[heapPkg::IndexBits-1:0];
    end else if (head.op == heapPkg::OpPop) begin
      elemIndex = heapPkg::index_t'(sizeNow - 1'b1);
    end
  end

  assign elemNow = memory[head.array][elemIndex];
  assign elemSum = elemNow + head.data;               // Wraps at 12 bits

  // ------------------------------------------------------------------
  // Checks in order: never allocated, freed, bounds, capacity
  // ------------------------------------------------------------------
  always_comb begin
    cmdError = heapPkg::ErrNone;
    allocId  = usedCount[heapPkg::ArrayBits-1:0];     // Next never-used array
    if (head.op == heapPkg::OpAlloc) begin
      if (freeTop != '0) begin
        allocId = freeStack[heapPkg::arrayId_t'(freeTop - 1'b1)];
      end else if (usedCount == arrayCount_t'(ArrayCount)) begin
        cmdError = heapPkg::ErrOutOfMemory;
      end
    end else if ({1'b0, head.array} >= usedCount) begin
      cmdError = heapPkg::ErrNotAllocated;
    end else if (!allocated[head.array]) begin
      cmdError = heapPkg::ErrFreed;
    end else begin
      case (head.op)
        heapPkg::OpRead, heapPkg::OpAdd: begin
          if ({1'b0, head.index} >= sizeNow) cmdError = heapPkg::ErrOutOfBounds;
        end
        heapPkg::OpPush: begin
          if (sizeNow == heapPkg::size_t'(ArrayLength)) cmdError = heapPkg::ErrFull;
        end
        heapPkg::OpPop: begin
          if (sizeNow == '0) cmdError = heapPkg::ErrEmpty;
        end
        default: ;
      endcase
    end
  end

  // Data word of the response, zero on any error and for Free
  always_comb begin
    resultData = '0;
    if (cmdError == heapPkg::ErrNone) begin
      case (head.op)
        heapPkg::OpAlloc:                 resultData = heapPkg::data_t'(allocId);
        heapPkg::OpWrite, heapPkg::OpPush: resultData = head.data;
        heapPkg::OpRead, heapPkg::OpPop:   resultData = elemNow;
        heapPkg::OpSize:                  resultData = heapPkg::data_t'(sizeNow);
        heapPkg::OpAdd:                   resultData = elemSum;
        default:                          resultData = '0;
      endcase
    end
  end

  assign memWrite = execute && (head.op == heapPkg::OpWrite ||
                                head.op == heapPkg::OpPush ||
                                head.op == heapPkg::OpAdd);

  // ------------------------------------------------------------------
  // Control state update
  // ------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated   <= '0;
      freeTop     <= '0;
      usedCount   <= '0;
      resultValid <= 1'b0;
      for (int i = 0; i < ArrayCount; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      resultValid <= take;                            // One response per take
      if (execute) begin
        case (head.op)
          heapPkg::OpAlloc: begin
            allocated[allocId] <= 1'b1;
            sizes[allocId]     <= '0;                 // Starts empty
            if (freeTop != '0) begin
              freeTop <= freeTop - 1'b1;
            end else begin
              usedCount <= usedCount + 1'b1;
            end
          end
          heapPkg::OpFree: begin
            allocated[head.array] <= 1'b0;
            freeTop               <= freeTop + 1'b1;
          end
          heapPkg::OpWrite: begin
            if ({1'b0, head.index} >= sizeNow) begin
              sizes[head.array] <= {1'b0, head.index} + 1'b1;
            end
          end
          heapPkg::OpPush: sizes[head.array] <= sizeNow + 1'b1;
          heapPkg::OpPop:  sizes[head.array] <= sizeNow - 1'b1;
          default: ;
        endcase
      end
    end
  end

  // Elements, free stack and response payload
  always_ff @(posedge clock) begin
    if (memWrite) begin
      memory[head.array][elemIndex] <= (head.op == heapPkg::OpAdd) ? elemSum : head.data;
    end
    if (execute && head.op == heapPkg::OpFree) begin
      freeStack[heapPkg::arrayId_t'(freeTop)] <= head.array;
    end
    if (take) begin
      result <= '{data: resultData, error: cmdError};
    end
  end

  // Only arrays once handed out can sit on the free stack
  freeStackBounded: assert property (@(posedge clock) disable iff (!resetN)
    freeTop <= usedCount);

endmodule

`default_nettype wire

// ==== verilog/heapResponseQueue.sv ====
/*
  Heap unit response queue
  FIFO for results, sends only while consumer credit is held
*/
`timescale 1ns/1ps
`default_nettype none

module heapResponseQueue #(
  parameter int ResponseDepth   = 4,
  parameter int ResponseCredits = 4
) (
  input  wire                         clock,
  input  wire                         resetN,
  input  wire heapPkg::heapResponse_t result,
  input  wire                         resultValid,
  input  wire                         responseCredit,
  output logic                        hasSpace,
  output heapPkg::heapResponse_t      response,
  output logic                        responseValid
);

  localparam int PtrBits    = (ResponseDepth > 1) ? $clog2(ResponseDepth) : 1;
  localparam int CountBits  = $clog2(ResponseDepth + 1);
  localparam int CreditBits = $clog2(ResponseCredits + 1);
  localparam logic [PtrBits-1:0] LastSlot = PtrBits'(ResponseDepth - 1);

  heapPkg::heapResponse_t entries [ResponseDepth];
  logic [PtrBits-1:0]     readPtr;
  logic [PtrBits-1:0]     writePtr;
  logic [CountBits-1:0]   fill;
  logic [CreditBits-1:0]  credits;                    // Free slots at the consumer

  assign response      = entries[readPtr];
  assign responseValid = (fill != '0) && (credits != '0);

  // A result already registered in the store still needs a slot
  assign hasSpace = (int'(fill) + int'(resultValid)) < ResponseDepth;

  // ------------------------------------------------------------------
  // Pointers, fill count and consumer credits
  // ------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      readPtr  <= '0;
      writePtr <= '0;
      fill     <= '0;
      credits  <= CreditBits'(ResponseCredits);
    end else begin
      if (resultValid) begin
        writePtr <= (writePtr == LastSlot) ? '0 : writePtr + 1'b1;
      end
      if (responseValid) begin
        readPtr <= (readPtr == LastSlot) ? '0 : readPtr + 1'b1;
      end
      fill    <= fill + CountBits'(resultValid) - CountBits'(responseValid);
      credits <= credits + CreditBits'(responseCredit) - CreditBits'(responseValid);
    end
  end

  always_ff @(posedge clock) begin
    if (resultValid) begin
      entries[writePtr] <= result;
    end
  end

  // Consumer never returns more than its buffer size
  creditsBounded: assert property (@(posedge clock) disable iff (!resetN)
    credits <= CreditBits'(ResponseCredits));

endmodule

`default_nettype wire

// ==== verilog/heapUnit.sv ====
/*
  Heap array unit top
  Command queue, array store and response queue in a row
*/
`timescale 1ns/1ps
`default_nettype none

module heapUnit #(
  parameter int QueueDepth      = 4,
  parameter int ResponseDepth   = 4,
  parameter int ResponseCredits = 4
) (
  input  wire                        clock,
  input  wire                        resetN,
  input  wire heapPkg::heapCommand_t command,
  input  wire                        commandValid,
  output logic                       commandCredit,
  output heapPkg::heapResponse_t     response,
  output logic                       responseValid,
  input  wire                        responseCredit
);

  heapPkg::heapCommand_t  head;
  logic                   headValid;
  logic                   take;
  logic                   hasSpace;
  heapPkg::heapResponse_t result;
  logic                   resultValid;

  // ------------------------------------------------------------------
  // Input side, store, output side
  // ------------------------------------------------------------------
  heapCommandQueue #(.QueueDepth(QueueDepth)) commandQueue_i (
    .clock(clock), .resetN(resetN),
    .command(command), .commandValid(commandValid),
    .take(take), .head(head), .headValid(headValid),
    .commandCredit(commandCredit)
  );

  heapArrayStore arrayStore_i (
    .clock(clock), .resetN(resetN),
    .head(head), .headValid(headValid), .hasSpace(hasSpace),
    .take(take), .result(result), .resultValid(resultValid)
  );

  heapResponseQueue #(
    .ResponseDepth(ResponseDepth),
    .ResponseCredits(ResponseCredits)
  ) responseQueue_i (
    .clock(clock), .resetN(resetN),
    .result(result), .resultValid(resultValid),
    .responseCredit(responseCredit), .hasSpace(hasSpace),
    .response(response), .responseValid(responseValid)
  );

endmodule

`default_nettype wire

// ==== tb/heapUnitTb.sv ====
/*
  Heap array unit testbench
  Directed and random commands under credit flow control, each
  response checked against a reference model of arrays and free stack
*/
`timescale 1ns/1ps
`default_nettype none

module heapUnitTb;

  localparam int QueueDepth       = 4;
  localparam int ResponseDepth    = 4;
  localparam int ResponseCredits  = 4;
  localparam int ArrayCount       = 1 << heapPkg::ArrayBits;
  localparam int ArrayLength      = 1 << heapPkg::IndexBits;
  localparam int DirectedCommands = 71;
  localparam int RandomCommands   = 400;
  localparam int CycleLimit       = 40 * (DirectedCommands + RandomCommands);
  localparam logic [31:0] Seed    = 32'hcae444e2;

  logic                   clock;
  logic                   resetN;
  heapPkg::heapCommand_t  command;
  logic                   commandValid;
  logic                   commandCredit;
  heapPkg::heapResponse_t response;
  logic                   responseValid;
  logic                   responseCredit = 1'b0;

  heapPkg::heapResponse_t expected [$];               // Model results in command order
  heapPkg::data_t         modelMem [ArrayCount][ArrayLength];
  int                     modelSize [ArrayCount];
  int                     modelState [ArrayCount];    // 0 never, 1 allocated, 2 freed
  int                     freeList [$];               // Last freed at the back
  int                     nextFresh;
  logic [31:0]            stimState;
  logic [31:0]            creditState;
  int                     producerCredits;
  int                     heldCredits;
  int                     owedCredits;
  int                     sentCount;
  int                     receivedCount;
  int                     creditPulses;
  int                     cycles;
  int                     checkCount;
  int                     errorCount;
  int                     testChecks;
  int                     testErrors;
  logic                   sparseCredits;

  heapUnit #(
    .QueueDepth(QueueDepth),
    .ResponseDepth(ResponseDepth),
    .ResponseCredits(ResponseCredits)
  ) dut_i (
    .clock(clock), .resetN(resetN),
    .command(command), .commandValid(commandValid), .commandCredit(commandCredit),
    .response(response), .responseValid(responseValid), .responseCredit(responseCredit)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // ------------------------------------------------------------------
  // Random bits and reference model
  // ------------------------------------------------------------------
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int unsigned stimBits(input int n);
    int unsigned v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | stimState[0];
      stimState = lfsrStep(stimState);
    end
    return v;
  endfunction

  // One chance in four
  function automatic logic creditChance();
    logic hit;
    hit = !creditState[0];
    creditState = lfsrStep(creditState);
    hit = hit && !creditState[0];
    creditState = lfsrStep(creditState);
    return hit;
  endfunction

  function automatic heapPkg::heapResponse_t expectResponse(input heapPkg::heapCommand_t cmd);
    heapPkg::heapResponse_t r;
    int a;
    int i;
    a = int'(cmd.array);
    i = int'(cmd.index);
    r.data  = '0;
    r.error = heapPkg::ErrNone;
    if (cmd.op == heapPkg::OpAlloc) begin
      if (freeList.size() > 0) begin
        a = freeList.pop_back();                      // Most recently freed first
      end else if (nextFresh < ArrayCount) begin
        a = nextFresh;
        nextFresh++;
      end else begin
        r.error = heapPkg::ErrOutOfMemory;
      end
      if (r.error == heapPkg::ErrNone) begin
        modelState[a] = 1;
        modelSize[a]  = 0;
        r.data        = heapPkg::data_t'(a);
      end
    end else if (modelState[a] == 0) begin
      r.error = heapPkg::ErrNotAllocated;
    end else if (modelState[a] == 2) begin
      r.error = heapPkg::ErrFreed;
    end else begin
      case (cmd.op)
        heapPkg::OpFree: begin
          modelState[a] = 2;
          freeList.push_back(a);
        end
        heapPkg::OpWrite: begin
          if (i >= modelSize[a]) modelSize[a] = i + 1;
          modelMem[a][i] = cmd.data;
          r.data = cmd.data;
        end
        heapPkg::OpRead: begin
          if (i < modelSize[a]) r.data = modelMem[a][i];
          else r.error = heapPkg::ErrOutOfBounds;
        end
        heapPkg::OpSize: r.data = heapPkg::data_t'(modelSize[a]);
        heapPkg::OpPush: begin
          if (modelSize[a] == ArrayLength) begin
            r.error = heapPkg::ErrFull;
          end else begin
            modelMem[a][modelSize[a]] = cmd.data;
            modelSize[a]++;
            r.data = cmd.data;
          end
        end
        heapPkg::OpPop: begin
          if (modelSize[a] == 0) begin
            r.error = heapPkg::ErrEmpty;
          end else begin
            modelSize[a]--;
            r.data = modelMem[a][modelSize[a]];
          end
        end
        heapPkg::OpAdd: begin
          if (i < modelSize[a]) begin
            modelMem[a][i] = modelMem[a][i] + cmd.data;   // Wraps at 12 bits
            r.data = modelMem[a][i];
          end else begin
            r.error = heapPkg::ErrOutOfBounds;
          end
        end
        default: ;
      endcase
    end
    return r;
  endfunction

  // ------------------------------------------------------------------
  // Producer side
  // ------------------------------------------------------------------
  task automatic nextCycle();
    @(negedge clock);
    commandValid = 1'b0;
    if (commandCredit) begin                          // Credit back from the queue
      producerCredits++;
      creditPulses++;
    end
  endtask

  task automatic sendCommand(input heapPkg::heapOp_t op, input int array, input int index,
                             input int data);
    heapPkg::heapCommand_t cmd;
    cmd.op    = op;
    cmd.array = heapPkg::arrayId_t'(array);
    cmd.index = heapPkg::index_t'(index);
    cmd.data  = heapPkg::data_t'(data);
    while (producerCredits == 0) nextCycle();
    command      = cmd;
    commandValid = 1'b1;
    producerCredits--;
    sentCount++;
    expected.push_back(expectResponse(cmd));
    nextCycle();
  endtask

  task automatic drainAndReport(input string name);
    while (receivedCount != sentCount) nextCycle();
    nextCycle();
    $display("%s: %0d checks, %0d errors", name, checkCount - testChecks,
             errorCount - testErrors);
    testChecks = checkCount;
    testErrors = errorCount;
  endtask

  // ------------------------------------------------------------------
  // Consumer side and compare
  // ------------------------------------------------------------------
  always @(negedge clock) begin
    heapPkg::heapResponse_t want;
    if (resetN) begin
      if (responseValid) begin
        assert (heldCredits > 0) else begin
          $display("Response sent at %0t while the consumer held no credit", $time);
          errorCount++;
        end
        heldCredits--;
        owedCredits++;
        receivedCount++;
        if (expected.size() == 0) begin
          $display("Response at %0t with no command outstanding", $time);
          errorCount++;
        end else begin
          want = expected.pop_front();
          checkCount++;
          assert (response.data == want.data) else begin
            $display("Fail at %0t: response.data expected %h got %h", $time,
                     want.data, response.data);
            errorCount++;
          end
          assert (response.error == want.error) else begin
            $display("Fail at %0t: response.error expected %0d got %0d", $time,
                     want.error, response.error);
            errorCount++;
          end
        end
      end
      // Buffer slots go back sparsely in the random test
      if (owedCredits > 0 && (!sparseCredits || creditChance())) begin
        responseCredit = 1'b1;
        owedCredits--;
        heldCredits++;
      end else begin
        responseCredit = 1'b0;
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > CycleLimit) begin
      $display("Run stopped after %0d cycles with %0d of %0d responses received",
               cycles, receivedCount, sentCount);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------
  initial begin
    int op;
    int arr;
    int idx;
    int dat;
    stimState       = Seed;
    creditState     = Seed;
    nextFresh       = 0;
    producerCredits = QueueDepth;
    heldCredits     = ResponseCredits;
    owedCredits     = 0;
    sentCount       = 0;
    receivedCount   = 0;
    creditPulses    = 0;
    cycles          = 0;
    checkCount      = 0;
    errorCount      = 0;
    testChecks      = 0;
    testErrors      = 0;
    sparseCredits   = 1'b0;
    for (int a = 0; a < ArrayCount; a++) begin
      modelSize[a]  = 0;
      modelState[a] = 0;
    end
    resetN       = 1'b0;
    command      = '0;
    commandValid = 1'b0;
    repeat (8) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;

    sendCommand(heapPkg::OpSize, 3, 0, 0);            // Nothing handed out yet
    for (int a = 0; a < 5; a++) sendCommand(heapPkg::OpAlloc, 0, 0, 0);
    for (int a = 0; a < ArrayCount; a++) begin
      for (int i = 0; i < ArrayLength; i++) begin
        sendCommand(heapPkg::OpWrite, a, i, (a << 8) ^ (i * 37) ^ 12'h5a5);
      end
    end
    sendCommand(heapPkg::OpFree, 2, 0, 0);
    sendCommand(heapPkg::OpAlloc, 0, 0, 0);           // Array 2 again
    drainAndReport("Test 1 alloc and free");

    sendCommand(heapPkg::OpWrite, 2, 5, 12'h3c1);
    sendCommand(heapPkg::OpSize, 2, 0, 0);
    sendCommand(heapPkg::OpRead, 2, 5, 0);
    sendCommand(heapPkg::OpRead, 2, 4, 0);
    sendCommand(heapPkg::OpRead, 2, 6, 0);            // At the size
    drainAndReport("Test 2 write, size and read");

    sendCommand(heapPkg::OpFree, 1, 0, 0);
    sendCommand(heapPkg::OpAlloc, 0, 0, 0);
    for (int i = 0; i < 9; i++) sendCommand(heapPkg::OpPush, 1, 0, 100 + i * 3);
    for (int i = 0; i < 9; i++) sendCommand(heapPkg::OpPop, 1, 0, 0);
    drainAndReport("Test 3 push and pop");

    sendCommand(heapPkg::OpAdd, 0, 3, 12'hfff);
    sendCommand(heapPkg::OpAdd, 0, 3, 12'h005);
    sendCommand(heapPkg::OpFree, 3, 0, 0);
    sendCommand(heapPkg::OpRead, 3, 0, 0);
    sendCommand(heapPkg::OpFree, 3, 0, 0);            // Second free of the same array
    sendCommand(heapPkg::OpAlloc, 0, 0, 0);
    drainAndReport("Test 4 add and freed arrays");

    sparseCredits = 1'b1;
    for (int n = 0; n < RandomCommands; n++) begin
      while (stimBits(2) == 0) nextCycle();           // Producer stall
      op  = int'(stimBits(3));
      arr = int'(stimBits(2));
      idx = int'(stimBits(3));
      dat = int'(stimBits(12));
      sendCommand(heapPkg::heapOp_t'(op), arr, idx, dat);
    end
    drainAndReport("Test 5 random mix");

    assert (creditPulses == sentCount) else begin
      $display("Command credits returned %0d but %0d commands were sent",
               creditPulses, sentCount);
      errorCount++;
    end
    $display("Total: %0d commands, %0d checks, %0d errors", sentCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/heapPkg.sv
verilog/heapCommandQueue.sv
verilog/heapArrayStore.sv
verilog/heapResponseQueue.sv
verilog/heapUnit.sv
tb/heapUnitTb.sv

// ==== Bender.yml ====
package:
  name: heap_unit

sources:
  - verilog/heapPkg.sv
  - verilog/heapCommandQueue.sv
  - verilog/heapArrayStore.sv
  - verilog/heapResponseQueue.sv
  - verilog/heapUnit.sv
  - target: test
    files:
      - tb/heapUnitTb.sv
